/* logic/intra_pkg.sv */
package intra_pkg;

  // sample and block geometry
  localparam int PIXEL_WIDTH = 8;
  localparam int BLK_SIDE    = 4;

  // wide enough for the full luma mode range
  localparam int MODE_WIDTH  = 6;

  // one luma sample
  typedef logic [PIXEL_WIDTH-1:0] pixel_t;

  // one block edge, pixel 0 in the top byte
  typedef logic [BLK_SIDE*PIXEL_WIDTH-1:0] edge_t;

  // whole 4x4 block in raster order, pixel 0 in the top byte
  typedef logic [BLK_SIDE*BLK_SIDE*PIXEL_WIDTH-1:0] blk_pix_t;

  typedef logic [MODE_WIDTH-1:0] mode_t;

  // modes predicted natively
  localparam mode_t MODE_DC  = mode_t'(1);
  localparam mode_t MODE_HOR = mode_t'(10);
  localparam mode_t MODE_VER = mode_t'(26);

  // stand-in for a missing neighbour, half of the sample range
  localparam pixel_t PIX_HALF = pixel_t'(1 << (PIXEL_WIDTH - 1));

endpackage

/* logic/intra_ctrl.sv */
module intra_ctrl #(
  parameter int LCU_BLKS = 4
) (
  input  logic                          clk,
  input  logic                          reset_i,
  // lcu control
  input  logic                          start_i,
  output logic                          done_o,
  // mode memory
  output logic                          md_rden_o,
  output logic [2*$clog2(LCU_BLKS)-1:0] md_raddr_o,
  input  intra_pkg::mode_t              md_rdata_i,
  // reconstruction strobe
  input  logic                          rec_val_i,
  output logic                          rec_wr_o,
  // current block
  output logic [$clog2(LCU_BLKS)-1:0]   blk_x_o,
  output logic [$clog2(LCU_BLKS)-1:0]   blk_y_o,
  // predictor control
  output logic                          pred_start_o,
  output intra_pkg::mode_t              mode_o
);

  localparam int IDX_W = $clog2(LCU_BLKS);

  // one pass per 4x4 block: read mode, capture it, wait for rec
  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_CAP,
    S_WAIT
  } state_t;

  state_t             state;
  state_t             state_nxt;
  logic [2*IDX_W-1:0] blk_idx;
  logic               last_blk;
  logic               start_acc;
  intra_pkg::mode_t   mode_q;

  // z-scan index doubles as the mode memory address
  assign md_raddr_o = blk_idx;
  assign last_blk   = &blk_idx;

  // start only counts when idle
  assign start_acc = (state == S_IDLE) && start_i;

  // rec strobes outside the wait are dropped
  assign rec_wr_o = (state == S_WAIT) && rec_val_i;

  assign md_rden_o    = (state == S_READ);
  assign pred_start_o = (state == S_CAP);

  // predictor sees the memory word while capturing, the held copy afterwards
  assign mode_o = (state == S_CAP) ? md_rdata_i : mode_q;

  // even index bits give x, odd bits give y
  always_comb begin
    for (int i = 0; i < IDX_W; i++) begin
      blk_x_o[i] = blk_idx[2*i];
      blk_y_o[i] = blk_idx[2*i+1];
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (start_i) begin
          state_nxt = S_READ;
        end
      end
      S_READ: begin
        state_nxt = S_CAP;
      end
      S_CAP: begin
        state_nxt = S_WAIT;
      end
      S_WAIT: begin
        // hold here as long as the transform side needs
        if (rec_val_i) begin
          state_nxt = last_blk ? S_IDLE : S_READ;
        end
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= S_IDLE;
      blk_idx <= '0;
      done_o  <= 1'b0;
    end else begin
      state  <= state_nxt;
      done_o <= rec_wr_o && last_blk;
      if (start_acc) begin
        blk_idx <= '0;
      end else if (rec_wr_o && !last_blk) begin
        blk_idx <= blk_idx + 1'b1;
      end
    end
  end

  // mode stays put until the next block is captured
  always_ff @(posedge clk) begin
    if (state == S_CAP) begin
      mode_q <= md_rdata_i;
    end
  end

endmodule

/* logic/intra_ref.sv */
module intra_ref #(
  parameter int LCU_BLKS = 4
) (
  input  logic                        clk,
  input  logic                        reset_i,
  // block being predicted or reconstructed
  input  logic [$clog2(LCU_BLKS)-1:0] blk_x_i,
  input  logic [$clog2(LCU_BLKS)-1:0] blk_y_i,
  // reconstruction write
  input  logic                        rec_wr_i,
  input  intra_pkg::blk_pix_t         rec_data_i,
  // neighbours for the predictor
  output intra_pkg::edge_t            ref_top_o,
  output intra_pkg::edge_t            ref_left_o
);

  localparam int IDX_W = $clog2(LCU_BLKS);
  localparam int PW    = intra_pkg::PIXEL_WIDTH;
  localparam int SIDE  = intra_pkg::BLK_SIDE;

  // bottom row of the latest block in each column
  intra_pkg::edge_t    row_buf [LCU_BLKS];
  // right column of the latest block in each row
  intra_pkg::edge_t    col_buf [LCU_BLKS];

  intra_pkg::edge_t bot_edge;
  intra_pkg::edge_t rgt_edge;
  intra_pkg::edge_t half_edge;
  logic             top_avail;
  logic             left_avail;

  assign half_edge = {SIDE{intra_pkg::PIX_HALF}};

  // last raster row sits in the low bytes
  assign bot_edge = rec_data_i[SIDE*PW-1:0];

  // gather the last pixel of every row, top pixel first
  always_comb begin
    for (int r = 0; r < SIDE; r++) begin
      rgt_edge[(SIDE-1-r)*PW +: PW] = rec_data_i[SIDE*(SIDE-1-r)*PW +: PW];
    end
  end

  always_ff @(posedge clk) begin
    if (rec_wr_i) begin
      row_buf[blk_x_i] <= bot_edge;
      col_buf[blk_y_i] <= rgt_edge;
    end
  end

  // nothing across the lcu top row or left column
  assign top_avail  = (blk_y_i != IDX_W'(0));
  assign left_avail = (blk_x_i != IDX_W'(0));

  assign ref_top_o  = top_avail  ? row_buf[blk_x_i] : half_edge;
  assign ref_left_o = left_avail ? col_buf[blk_y_i] : half_edge;

endmodule

/* logic/intra_pred.sv */
module intra_pred (
  input  logic                clk,
  input  logic                reset_i,
  // controller side
  input  logic                pred_start_i,
  input  intra_pkg::mode_t    mode_i,
  // neighbours, pixel 0 in the top byte
  input  intra_pkg::edge_t    ref_top_i,
  input  intra_pkg::edge_t    ref_left_i,
  // predicted block
  output logic                pre_en_o,
  output intra_pkg::blk_pix_t pre_data_o
);

  localparam int PW    = intra_pkg::PIXEL_WIDTH;
  localparam int SIDE  = intra_pkg::BLK_SIDE;
  // log2 of the eight references averaged by DC
  localparam int DC_SH = $clog2(2 * SIDE);
  localparam int SUM_W = PW + DC_SH;

  logic [SUM_W-1:0]    dc_sum;
  intra_pkg::pixel_t   dc_val;
  intra_pkg::blk_pix_t dc_blk;
  intra_pkg::blk_pix_t hor_blk;
  intra_pkg::blk_pix_t ver_blk;
  intra_pkg::blk_pix_t pred_blk;

  // rounding term is half the divisor
  always_comb begin
    dc_sum = SUM_W'(SIDE);
    for (int i = 0; i < SIDE; i++) begin
      dc_sum = dc_sum + SUM_W'(ref_top_i[i*PW +: PW]) + SUM_W'(ref_left_i[i*PW +: PW]);
    end
  end

  assign dc_val = intra_pkg::pixel_t'(dc_sum >> DC_SH);
  assign dc_blk = {(SIDE*SIDE){dc_val}};

  // rows copy the left edge, columns copy the top edge
  always_comb begin
    for (int r = 0; r < SIDE; r++) begin
      for (int c = 0; c < SIDE; c++) begin
        hor_blk[(SIDE*SIDE-1-r*SIDE-c)*PW +: PW] = ref_left_i[(SIDE-1-r)*PW +: PW];
        ver_blk[(SIDE*SIDE-1-r*SIDE-c)*PW +: PW] = ref_top_i[(SIDE-1-c)*PW +: PW];
      end
    end
  end

  always_comb begin
    case (mode_i)
      intra_pkg::MODE_DC: begin
        pred_blk = dc_blk;
      end
      intra_pkg::MODE_HOR: begin
        pred_blk = hor_blk;
      end
      intra_pkg::MODE_VER: begin
        pred_blk = ver_blk;
      end
      // angular and planar modes fall back to DC
      default: begin
        pred_blk = dc_blk;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pre_en_o <= 1'b0;
    end else begin
      pre_en_o <= pred_start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pred_start_i) begin
      pre_data_o <= pred_blk;
    end
  end

endmodule

/* logic/intra_top.sv */
module intra_top #(
  parameter int LCU_BLKS = 4
) (
  input  logic                          clk,
  input  logic                          reset_i,
  // lcu control
  input  logic                          start_i,
  output logic                          done_o,
  // mode memory
  output logic                          md_rden_o,
  output logic [2*$clog2(LCU_BLKS)-1:0] md_raddr_o,
  input  intra_pkg::mode_t              md_rdata_i,
  // prediction to transform side
  output logic                          pre_en_o,
  output intra_pkg::blk_pix_t           pre_data_o,
  output intra_pkg::mode_t              pre_mode_o,
  output logic [$clog2(LCU_BLKS)-1:0]   pre_4x4_x_o,
  output logic [$clog2(LCU_BLKS)-1:0]   pre_4x4_y_o,
  // reconstruction from transform side
  input  logic                          rec_val_i,
  input  intra_pkg::blk_pix_t           rec_data_i
);

  localparam int IDX_W = $clog2(LCU_BLKS);

  logic [IDX_W-1:0] blk_x_w;
  logic [IDX_W-1:0] blk_y_w;
  logic             rec_wr_w;
  logic             pred_start_w;
  intra_pkg::mode_t mode_w;
  intra_pkg::edge_t ref_top_w;
  intra_pkg::edge_t ref_left_w;

  // block position and mode leave straight from the controller
  assign pre_4x4_x_o = blk_x_w;
  assign pre_4x4_y_o = blk_y_w;
  assign pre_mode_o  = mode_w;

  intra_ctrl #(
    .LCU_BLKS     ( LCU_BLKS     )
  ) u_intra_ctrl (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .start_i      ( start_i      ),
    .done_o       ( done_o       ),
    .md_rden_o    ( md_rden_o    ),
    .md_raddr_o   ( md_raddr_o   ),
    .md_rdata_i   ( md_rdata_i   ),
    .rec_val_i    ( rec_val_i    ),
    .rec_wr_o     ( rec_wr_w     ),
    .blk_x_o      ( blk_x_w      ),
    .blk_y_o      ( blk_y_w      ),
    .pred_start_o ( pred_start_w ),
    .mode_o       ( mode_w       )
  );

  intra_ref #(
    .LCU_BLKS     ( LCU_BLKS     )
  ) u_intra_ref (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .blk_x_i      ( blk_x_w      ),
    .blk_y_i      ( blk_y_w      ),
    .rec_wr_i     ( rec_wr_w     ),
    .rec_data_i   ( rec_data_i   ),
    .ref_top_o    ( ref_top_w    ),
    .ref_left_o   ( ref_left_w   )
  );

  intra_pred u_intra_pred (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .pred_start_i ( pred_start_w ),
    .mode_i       ( mode_w       ),
    .ref_top_i    ( ref_top_w    ),
    .ref_left_i   ( ref_left_w   ),
    .pre_en_o     ( pre_en_o     ),
    .pre_data_o   ( pre_data_o   )
  );

endmodule

/* verification/intra_props.sv */
module intra_props (
  input logic clk,
  input logic reset_i,
  input logic done_o,
  input logic md_rden_o,
  input logic pre_en_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // nothing active in the cycle right after reset
  reset_quiet: assert property (
    @(posedge clk) reset_i |=> (!done_o && !md_rden_o && !pre_en_o)
  ) else $error("control output active right after reset");

  // mode read, capture, then the predicted block
  rden_to_pre: assert property (
    @(posedge clk) disable iff (reset_i) md_rden_o |-> ##2 pre_en_o
  ) else $error("pre_en_o missing two cycles after md_rden_o");

  pre_after_rden: assert property (
    @(posedge clk) disable iff (reset_i) pre_en_o |-> $past(md_rden_o, 2)
  ) else $error("pre_en_o without md_rden_o two cycles before");

  pre_pulse: assert property (
    @(posedge clk) disable iff (reset_i) pre_en_o |=> !pre_en_o
  ) else $error("pre_en_o held longer than one cycle");

  done_pulse: assert property (
    @(posedge clk) disable iff (reset_i) done_o |=> !done_o
  ) else $error("done_o held longer than one cycle");

endmodule

/* verification/intra_tb.sv */
module intra_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LCU_BLKS  = 4;
  localparam int IDX_W     = $clog2(LCU_BLKS);
  localparam int NBLK      = LCU_BLKS * LCU_BLKS;
  localparam int NUM_TESTS = 6;
  localparam int MAX_DELAY = 8;
  // each block costs about 4 cycles plus its rec delay, doubled for margin
  localparam int TIMEOUT   = NUM_TESTS * NBLK * (4 + MAX_DELAY) * 2;

  typedef struct {
    string name;
    bit    mode_rand;
    int    mode;
    bit    res_rand;
    int    max_delay;
    bit    poke;
  } test_t;

  logic                clk;
  logic                reset_i;
  logic                start_i;
  logic                done_o;
  logic                md_rden_o;
  logic [2*IDX_W-1:0]  md_raddr_o;
  intra_pkg::mode_t    md_rdata_i;
  logic                pre_en_o;
  intra_pkg::blk_pix_t pre_data_o;
  intra_pkg::mode_t    pre_mode_o;
  logic [IDX_W-1:0]    pre_4x4_x_o;
  logic [IDX_W-1:0]    pre_4x4_y_o;
  logic                rec_val_i;
  intra_pkg::blk_pix_t rec_data_i;

  test_t            tests [NUM_TESTS];
  intra_pkg::mode_t mode_mem [NBLK];
  // model line buffers: bottom row per column, right column per row
  int               row_ref [LCU_BLKS][4];
  int               col_ref [LCU_BLKS][4];
  int               pred_pix [16];
  int               cyc = 0;
  int               err_cnt = 0;
  int               check_cnt = 0;
  int               pass_cnt = 0;
  int               fail_cnt = 0;
  int               done_cnt = 0;
  int               done_cyc = 0;

  intra_top #(
    .LCU_BLKS    ( LCU_BLKS    )
  ) DUT (
    .clk         ( clk         ),
    .reset_i     ( reset_i     ),
    .start_i     ( start_i     ),
    .done_o      ( done_o      ),
    .md_rden_o   ( md_rden_o   ),
    .md_raddr_o  ( md_raddr_o  ),
    .md_rdata_i  ( md_rdata_i  ),
    .pre_en_o    ( pre_en_o    ),
    .pre_data_o  ( pre_data_o  ),
    .pre_mode_o  ( pre_mode_o  ),
    .pre_4x4_x_o ( pre_4x4_x_o ),
    .pre_4x4_y_o ( pre_4x4_y_o ),
    .rec_val_i   ( rec_val_i   ),
    .rec_data_i  ( rec_data_i  )
  );

  bind intra_top intra_props u_intra_props (
    .clk       ( clk       ),
    .reset_i   ( reset_i   ),
    .done_o    ( done_o    ),
    .md_rden_o ( md_rden_o ),
    .pre_en_o  ( pre_en_o  )
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("Test failed");
      $finish;
    end
  end

  // done pulses are counted on falling edges, read back on rising ones
  always @(negedge clk) begin
    if (done_o) begin
      done_cnt = done_cnt + 1;
      done_cyc = cyc;
    end
  end

  task automatic compare_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  // odd = 0 picks the even index bits (x), odd = 1 the odd bits (y)
  function automatic int zscan_coord(input int idx, input int odd);
    int v;
    v = 0;
    for (int i = 0; i < IDX_W; i++) begin
      v = v | (((idx >> (2 * i + odd)) & 1) << i);
    end
    return v;
  endfunction

  // edges of the lcu read as half range
  task automatic predict_block(input int x, input int y, input int mode,
                               output intra_pkg::blk_pix_t blk);
    int top [4];
    int left [4];
    int sum;
    sum = 4;
    for (int i = 0; i < 4; i++) begin
      top[i]  = (y == 0) ? 128 : row_ref[x][i];
      left[i] = (x == 0) ? 128 : col_ref[y][i];
      sum = sum + top[i] + left[i];
    end
    for (int p = 0; p < 16; p++) begin
      if (mode == int'(intra_pkg::MODE_HOR)) begin
        pred_pix[p] = left[p / 4];
      end else if (mode == int'(intra_pkg::MODE_VER)) begin
        pred_pix[p] = top[p % 4];
      end else begin
        pred_pix[p] = sum >> 3;
      end
      blk[(15 - p) * 8 +: 8] = 8'(pred_pix[p]);
    end
  endtask

  // transform side: prediction plus residual, clipped to 8 bits
  task automatic reconstruct(input int x, input int y, input bit res_rand,
                             output intra_pkg::blk_pix_t rec);
    int v;
    for (int p = 0; p < 16; p++) begin
      v = pred_pix[p] + (res_rand ? int'($urandom_range(63)) - 32 : 0);
      v = (v < 0) ? 0 : ((v > 255) ? 255 : v);
      rec[(15 - p) * 8 +: 8] = 8'(v);
      if (p >= 12) begin
        row_ref[x][p - 12] = v;
      end
      if (p % 4 == 3) begin
        col_ref[y][p / 4] = v;
      end
    end
  endtask

  task automatic run_test(input test_t t);
    intra_pkg::blk_pix_t exp_blk;
    intra_pkg::blk_pix_t rec_blk;
    logic [2*IDX_W-1:0]  rd_addr;
    int                  t_trig;
    int                  errs_before;
    int                  x;
    int                  y;
    int                  pick;
    errs_before = err_cnt;
    for (int b = 0; b < NBLK; b++) begin
      pick = t.mode_rand ? int'($urandom_range(3)) : 4;
      case (pick)
        0: mode_mem[b] = intra_pkg::MODE_DC;
        1: mode_mem[b] = intra_pkg::MODE_HOR;
        2: mode_mem[b] = intra_pkg::MODE_VER;
        3: mode_mem[b] = intra_pkg::mode_t'($urandom_range(63));
        default: mode_mem[b] = intra_pkg::mode_t'(t.mode);
      endcase
    end
    @(negedge clk);
    start_i = 1'b1;
    t_trig = cyc;
    for (int b = 0; b < NBLK; b++) begin
      x = zscan_coord(b, 0);
      y = zscan_coord(b, 1);
      @(negedge clk);
      start_i = 1'b0;
      rec_val_i = 1'b0;
      while (!md_rden_o) @(negedge clk);
      compare_value({t.name, " md_raddr"}, 128'(b), 128'(md_raddr_o));
      rd_addr = md_raddr_o;
      // the mode word is not there yet during the read cycle
      md_rdata_i = ~mode_mem[rd_addr];
      if (t.poke) begin
        // a start and a rec strobe while busy must both be ignored
        start_i = 1'b1;
        rec_val_i = 1'b1;
        rec_data_i = {4{$urandom()}};
      end
      @(negedge clk);
      start_i = 1'b0;
      rec_val_i = 1'b0;
      md_rdata_i = mode_mem[rd_addr];
      while (!pre_en_o) @(negedge clk);
      compare_value({t.name, " pre_en delay"}, 128'(t_trig + 3), 128'(cyc));
      predict_block(x, y, int'(mode_mem[b]), exp_blk);
      compare_value({t.name, " pre_data"}, exp_blk, pre_data_o);
      compare_value({t.name, " pre_mode"}, 128'(mode_mem[b]), 128'(pre_mode_o));
      compare_value({t.name, " pre_4x4_x"}, 128'(x), 128'(pre_4x4_x_o));
      compare_value({t.name, " pre_4x4_y"}, 128'(y), 128'(pre_4x4_y_o));
      repeat ($urandom_range(t.max_delay)) @(negedge clk);
      reconstruct(x, y, t.res_rand, rec_blk);
      rec_data_i = rec_blk;
      rec_val_i = 1'b1;
      t_trig = cyc;
    end
    @(negedge clk);
    rec_val_i = 1'b0;
    repeat (3) @(negedge clk);
    @(posedge clk);
    compare_value({t.name, " done count"}, 128'(1), 128'(done_cnt));
    compare_value({t.name, " done delay"}, 128'(t_trig + 1), 128'(done_cyc));
    done_cnt = 0;
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("PASS %s: %0d blocks checked", t.name, NBLK);
    end else begin
      fail_cnt++;
      $display("FAIL %s: %0d mismatches", t.name, err_cnt - errs_before);
    end
  endtask

  initial begin
    reset_i = 1'b1;
    start_i = 1'b0;
    rec_val_i = 1'b0;
    rec_data_i = '0;
    md_rdata_i = '0;
    void'($urandom(32'hff74_ceb5));
    // name, random modes, mode, random residual, max rec delay, busy pokes
    tests[0] = '{"dc_zero", 1'b0, 1, 1'b0, 0, 1'b0};
    tests[1] = '{"hor_residual", 1'b0, 10, 1'b1, 3, 1'b0};
    tests[2] = '{"ver_residual", 1'b0, 26, 1'b1, 3, 1'b0};
    tests[3] = '{"mixed_modes", 1'b1, 0, 1'b1, 8, 1'b0};
    tests[4] = '{"angular_as_dc", 1'b0, 18, 1'b1, 2, 1'b0};
    tests[5] = '{"busy_start", 1'b1, 0, 1'b1, 8, 1'b1};
    repeat (3) @(negedge clk);
    reset_i = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(tests[i]);
    end
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
logic/intra_pkg.sv
logic/intra_ctrl.sv
logic/intra_ref.sv
logic/intra_pred.sv
logic/intra_top.sv
verification/intra_props.sv
verification/intra_tb.sv

/* Makefile */
# Verilator build and run of the intra 4x4 testbench

VERILATOR ?= verilator
TOP       ?= intra_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
